// File: hw/pe_defs.svh
// ==========================================================
// Global constants for the modular-arithmetic PE array.
// Include wherever lane count, modulus, widths or latency
// are needed. Guarded, so repeated includes are harmless.
// ==========================================================
`ifndef PE_DEFS_SVH
`define PE_DEFS_SVH

`define PE_NUM_LANES     4
`define PE_Q             3329      // kyber prime
`define PE_COEFF_W       12
`define PE_PROD_W        24

// barrett multiplier is floor(2^24 / q)
`define PE_BARRETT_M     5039
`define PE_BARRETT_SHIFT 24

// mod_mul depth and the fixed input to result latency
`define PE_MUL_LAT       3
`define PE_LATENCY       5

`endif

// File: hw/pe_pkg.sv
// ==========================================================
// Shared types for the PE array: coefficients, raw products
// and the op code that travels with each sample.
// ==========================================================
`include "pe_defs.svh"

package pe_pkg;

    typedef logic [`PE_COEFF_W-1:0] coeff_t;    // value mod q
    typedef logic [`PE_PROD_W-1:0]  prod_t;     // unreduced product

    // codes 3 to 5 are unused
    typedef enum logic [2:0] {
        OP_MADD   = 3'd0,
        OP_MSUB   = 3'd1,
        OP_MMUL   = 3'd2,
        OP_CT_BFO = 3'd6,
        OP_GS_BFO = 3'd7
    } pe_op_t;

endpackage

// File: hw/pe_lane_if.sv
// ==========================================================
// One lane's operands, op, strobe and results.
// The array side drives the operands, the lane drives the
// results. A sample is taken on every edge with valid high.
// ==========================================================
`timescale 1ns/10ps

interface pe_lane_if import pe_pkg::*; ();

    logic   valid;
    pe_op_t op;
    coeff_t a;
    coeff_t b;
    coeff_t w;      // twiddle for the butterflies

    logic   out_valid;
    coeff_t res0;
    coeff_t res1;

    modport array (
        output valid, op, a, b, w,
        input  out_valid, res0, res1
    );

    modport lane (
        input  valid, op, a, b, w,
        output out_valid, res0, res1
    );

endinterface

// File: hw/mod_add_sub.sv
// ==========================================================
// Registered modular sum and difference of two coefficients.
// Both results are produced every cycle, one cycle latency.
// Operands are expected below q.
// ==========================================================
`timescale 1ns/10ps
`include "pe_defs.svh"

module mod_add_sub import pe_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  coeff_t a,
    input  coeff_t b,
    output coeff_t sum,
    output coeff_t diff
);

    localparam logic [`PE_COEFF_W:0] Q_EXT = `PE_Q;

    logic [`PE_COEFF_W:0] sum_raw;
    logic [`PE_COEFF_W:0] diff_raw;
    coeff_t               sum_next;
    coeff_t               diff_next;

    always_comb begin
        sum_raw  = {1'b0, a} + {1'b0, b};
        diff_raw = {1'b0, a} - {1'b0, b};   // msb is the borrow

        // at most one correction needed for inputs below q
        if (sum_raw >= Q_EXT) begin
            sum_next = coeff_t'(sum_raw - Q_EXT);
        end else begin
            sum_next = sum_raw[`PE_COEFF_W-1:0];
        end

        if (diff_raw[`PE_COEFF_W]) begin
            diff_next = coeff_t'(diff_raw + Q_EXT);
        end else begin
            diff_next = diff_raw[`PE_COEFF_W-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            sum  <= '0;
            diff <= '0;
        end else begin
            sum  <= sum_next;
            diff <= diff_next;
        end
    end

endmodule

// File: hw/mod_mul.sv
// ==========================================================
// Modular multiplier, a*b mod q, with Barrett reduction.
// Three register stages, accepts a new pair every cycle.
// Operands are expected below q.
// ==========================================================
`timescale 1ns/10ps
`include "pe_defs.svh"

module mod_mul import pe_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  coeff_t a,
    input  coeff_t b,
    output coeff_t p
);

    localparam int                   M_W       = $clog2(`PE_BARRETT_M + 1);
    localparam logic [M_W-1:0]       BARRETT_M = `PE_BARRETT_M;
    localparam coeff_t               Q         = `PE_Q;
    localparam logic [`PE_COEFF_W:0] Q_EXT     = `PE_Q;

    prod_t                     prod_s1;     // full product
    prod_t                     prod_s2;
    coeff_t                    quot_s2;     // quotient estimate
    logic [`PE_PROD_W+M_W-1:0] barrett;
    prod_t                     quot_q;
    logic [`PE_COEFF_W:0]      rem;

    always_comb begin
        barrett = prod_s1 * BARRETT_M;
        quot_q  = quot_s2 * Q;
        // estimate is low by at most one, so rem < 2q fits in 13 bits
        rem = prod_s2[`PE_COEFF_W:0] - quot_q[`PE_COEFF_W:0];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            prod_s1 <= '0;
            prod_s2 <= '0;
            quot_s2 <= '0;
            p       <= '0;
        end else begin
            // stage 1
            prod_s1 <= a * b;

            // stage 2
            prod_s2 <= prod_s1;
            quot_s2 <= coeff_t'(barrett >> `PE_BARRETT_SHIFT);

            // stage 3 with the final correction
            if (rem >= Q_EXT) begin
                p <= coeff_t'(rem - Q_EXT);
            end else begin
                p <= rem[`PE_COEFF_W-1:0];
            end
        end
    end

endmodule

// File: hw/pe_lane.sv
// ==========================================================
// One processing element. Routes operands through the front
// add/sub, the multiplier and the back add/sub according to
// the op carried with each sample. All ops finish after
// PE_LATENCY cycles, so mixed ops can stream back to back.
// ==========================================================
`timescale 1ns/10ps
`include "pe_defs.svh"

module pe_lane import pe_pkg::*; (
    input logic clk,
    input logic rst,
    pe_lane_if.lane lane
);

    localparam int A_DLY   = `PE_MUL_LAT + 1;   // a and front result wait for product
    localparam int CTL_DLY = `PE_LATENCY;

    // index k of each delay line holds the sample from k cycles back
    logic [CTL_DLY:1] vld_d;
    pe_op_t           op_d [1:CTL_DLY];
    coeff_t           a_d [1:A_DLY];
    coeff_t           fres_d [1:A_DLY];
    coeff_t           b_d1;
    coeff_t           w_d1;

    coeff_t front_sum;
    coeff_t front_diff;
    coeff_t fres;
    coeff_t mul_a;
    coeff_t mul_b;
    coeff_t mul_p;
    coeff_t back_a;
    coeff_t back_sum;
    coeff_t back_diff;
    coeff_t res0_next;
    coeff_t res1_next;

    mod_add_sub u_front (
        .clk  (clk),
        .rst  (rst),
        .a    (lane.a),
        .b    (lane.b),
        .sum  (front_sum),
        .diff (front_diff)
    );

    always_comb begin
        // multiplier operands at stage 1
        case (op_d[1])
            OP_CT_BFO: begin
                mul_a = b_d1;
                mul_b = w_d1;
            end
            OP_GS_BFO: begin
                mul_a = front_diff;     // (a-b)*w
                mul_b = w_d1;
            end
            default: begin
                mul_a = a_d[1];
                mul_b = b_d1;
            end
        endcase

        fres = (op_d[1] == OP_MSUB) ? front_diff : front_sum;

        // zero passes the product straight through the back sum
        back_a = (op_d[A_DLY] == OP_CT_BFO) ? a_d[A_DLY] : '0;
    end

    mod_mul u_mul (
        .clk (clk),
        .rst (rst),
        .a   (mul_a),
        .b   (mul_b),
        .p   (mul_p)
    );

    mod_add_sub u_back (
        .clk  (clk),
        .rst  (rst),
        .a    (back_a),
        .b    (mul_p),
        .sum  (back_sum),
        .diff (back_diff)
    );

    always_comb begin
        res0_next = '0;
        res1_next = '0;
        case (op_d[CTL_DLY])
            OP_MADD, OP_MSUB: begin
                res0_next = fres_d[A_DLY];
            end
            OP_MMUL: begin
                res0_next = back_sum;
            end
            OP_CT_BFO: begin
                res0_next = back_sum;   // a + b*w
                res1_next = back_diff;  // a - b*w
            end
            OP_GS_BFO: begin
                res0_next = fres_d[A_DLY];
                res1_next = back_sum;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            vld_d          <= '0;
            op_d           <= '{default: OP_MADD};
            a_d            <= '{default: '0};
            fres_d         <= '{default: '0};
            b_d1           <= '0;
            w_d1           <= '0;
            lane.out_valid <= 1'b0;
            lane.res0      <= '0;
            lane.res1      <= '0;
        end else begin
            vld_d <= {vld_d[CTL_DLY-1:1], lane.valid};
            op_d[1] <= lane.op;
            for (int i = 2; i <= CTL_DLY; i++) begin
                op_d[i] <= op_d[i-1];
            end

            a_d[1]    <= lane.a;
            fres_d[1] <= fres;
            for (int i = 2; i <= A_DLY; i++) begin
                a_d[i]    <= a_d[i-1];
                fres_d[i] <= fres_d[i-1];
            end
            b_d1 <= lane.b;
            w_d1 <= lane.w;

            // output register at stage 5
            lane.out_valid <= vld_d[CTL_DLY];
            lane.res0      <= res0_next;
            lane.res1      <= res1_next;
        end
    end

endmodule

// File: hw/pe_array_top.sv
// ==========================================================
// Top level of the PE array. Fans the shared strobe and op
// out to every lane and collects the per-lane results.
// Fixed latency, no back-pressure.
// ==========================================================
`timescale 1ns/10ps
`include "pe_defs.svh"

module pe_array_top import pe_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   in_valid,
    input  pe_op_t op,
    input  coeff_t a [`PE_NUM_LANES],
    input  coeff_t b [`PE_NUM_LANES],
    input  coeff_t w [`PE_NUM_LANES],
    output logic   out_valid,
    output coeff_t res0 [`PE_NUM_LANES],
    output coeff_t res1 [`PE_NUM_LANES]
);

    for (genvar g = 0; g < `PE_NUM_LANES; g++) begin : g_lane

        pe_lane_if lane_if ();

        assign lane_if.valid = in_valid;
        assign lane_if.op    = op;      // same op on every lane
        assign lane_if.a     = a[g];
        assign lane_if.b     = b[g];
        assign lane_if.w     = w[g];

        pe_lane u_lane (
            .clk  (clk),
            .rst  (rst),
            .lane (lane_if.lane)
        );

        assign res0[g] = lane_if.res0;
        assign res1[g] = lane_if.res1;

        // valid path is identical in all lanes
        if (g == 0) begin : g_valid
            assign out_valid = lane_if.out_valid;
        end

    end

endmodule

// File: tb/tb_pe_array.sv
// ==========================================================
// Self-checking testbench for the PE array top level.
// Streams a table of mixed ops with bubbles into the DUT and
// checks every result and its arrival cycle against a model
// of the modular arithmetic rules.
// ==========================================================
`timescale 1ns/10ps
`include "pe_defs.svh"

module tb_pe_array import pe_pkg::*; ();

    localparam int NL           = `PE_NUM_LANES;
    localparam int Q            = `PE_Q;
    localparam int N_ENTRIES    = 72;
    localparam int N_FIXED      = 8;
    localparam int RESET_CYCLES = 16;
    localparam int WAIT_LIMIT   = 50;     // cycles per wait for out_valid
    localparam int TAIL_CYCLES  = 12;

    logic   clk;
    logic   rst;
    logic   in_valid;
    pe_op_t op;
    coeff_t a [NL];
    coeff_t b [NL];
    coeff_t w [NL];
    logic   out_valid;
    coeff_t res0 [NL];
    coeff_t res1 [NL];

    // stimulus table with expected results per entry
    logic        tbl_vld [N_ENTRIES];
    pe_op_t      tbl_op  [N_ENTRIES];
    int unsigned tbl_a   [N_ENTRIES][NL];
    int unsigned tbl_b   [N_ENTRIES][NL];
    int unsigned tbl_w   [N_ENTRIES][NL];
    int unsigned tbl_r0  [N_ENTRIES][NL];
    int unsigned tbl_r1  [N_ENTRIES][NL];
    int          n_valid;

    int          pend_idx [$];     // entries in flight
    int          pend_edge [$];    // edge count at which each is due
    int          edge_cnt = 0;
    logic [31:0] lfsr_state = 32'h4014_e3ae;

    pe_array_top i_dut (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .op        (op),
        .a         (a),
        .b         (b),
        .w         (w),
        .out_valid (out_valid),
        .res0      (res0),
        .res1      (res1)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) edge_cnt <= edge_cnt + 1;

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic take_bits(input int nbits, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            val = {val[30:0], lfsr_state[0]};
        end
    endtask

    task automatic rand_coeff(output int unsigned val);
        logic [31:0] r;
        take_bits(`PE_COEFF_W, r);
        val = r % Q;
    endtask

    function automatic pe_op_t op_from_index(input int k);
        case (k)
            0:       return OP_MADD;
            1:       return OP_MSUB;
            2:       return OP_MMUL;
            3:       return OP_CT_BFO;
            default: return OP_GS_BFO;
        endcase
    endfunction

    function automatic int unsigned mod_q(input int x);
        int r;
        r = x % Q;
        if (r < 0) begin
            r = r + Q;
        end
        return r;
    endfunction

    function automatic int unsigned model_res0(input pe_op_t o, input int x,
                                               input int y, input int t);
        case (o)
            OP_MADD:   return mod_q(x + y);
            OP_MSUB:   return mod_q(x - y);
            OP_MMUL:   return mod_q(x * y);
            OP_CT_BFO: return mod_q(x + mod_q(y * t));
            OP_GS_BFO: return mod_q(x + y);
            default:   return 0;
        endcase
    endfunction

    function automatic int unsigned model_res1(input pe_op_t o, input int x,
                                               input int y, input int t);
        case (o)
            OP_CT_BFO: return mod_q(x - mod_q(y * t));
            OP_GS_BFO: return mod_q(mod_q(x - y) * t);
            default:   return 0;
        endcase
    endfunction

    task automatic stop_run();
        $display("tests failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic set_ctl(input int idx, input logic vld, input pe_op_t o);
        tbl_vld[idx] = vld;
        tbl_op[idx]  = o;
    endtask

    task automatic set_lane(input int idx, input int l, input int unsigned x,
                            input int unsigned y, input int unsigned t);
        tbl_a[idx][l] = x;
        tbl_b[idx][l] = y;
        tbl_w[idx][l] = t;
    endtask

    task automatic build_table();
        logic [31:0] r;
        // wrap edges for add and subtract
        set_ctl(0, 1'b1, OP_MADD);
        set_lane(0, 0, Q - 1, Q - 1, 0);
        set_lane(0, 1, 0, 0, 0);
        set_lane(0, 2, Q - 1, 1, 0);
        set_lane(0, 3, 1234, 2095, 0);
        set_ctl(1, 1'b1, OP_MSUB);
        set_lane(1, 0, 0, 1, 0);
        set_lane(1, 1, 777, 777, 0);
        set_lane(1, 2, Q - 1, 0, 0);
        set_lane(1, 3, 0, Q - 1, 0);
        set_ctl(2, 1'b1, OP_MMUL);
        set_lane(2, 0, Q - 1, Q - 1, 0);
        set_lane(2, 1, 1, 2718, 0);
        set_lane(2, 2, 0, 3001, 0);
        set_lane(2, 3, 1500, 1, 0);
        set_ctl(3, 1'b0, OP_MMUL);         // bubble with ignored operands
        for (int l = 0; l < NL; l++) begin
            set_lane(3, l, Q - 1, Q - 1, Q - 1);
        end
        set_ctl(4, 1'b1, OP_CT_BFO);
        set_lane(4, 0, 0, Q - 1, Q - 1);
        set_lane(4, 1, Q - 1, Q - 1, Q - 1);
        set_lane(4, 2, 5, 7, 1);
        set_lane(4, 3, 100, 200, 17);
        set_ctl(5, 1'b1, OP_GS_BFO);
        set_lane(5, 0, 0, Q - 1, Q - 1);
        set_lane(5, 1, Q - 1, 0, Q - 1);
        set_lane(5, 2, 1, 2, 3000);
        set_lane(5, 3, 2000, 1000, 0);
        set_ctl(6, 1'b1, OP_CT_BFO);
        set_lane(6, 0, 10, 20, 0);
        set_lane(6, 1, Q - 1, 1, 1);
        set_lane(6, 2, 0, 0, Q - 1);
        set_lane(6, 3, Q - 1, Q - 1, 2);
        set_ctl(7, 1'b1, OP_GS_BFO);
        set_lane(7, 0, 5, 5, 123);
        set_lane(7, 1, 0, 1, 1);
        set_lane(7, 2, Q - 1, Q - 1, Q - 1);
        set_lane(7, 3, 17, 3000, 1729);

        // random part with roughly one bubble in four and a valid last entry
        for (int i = N_FIXED; i < N_ENTRIES; i++) begin
            take_bits(2, r);
            tbl_vld[i] = (r != 0) || (i == N_ENTRIES - 1);
            take_bits(3, r);
            tbl_op[i] = op_from_index(r % 5);
            for (int l = 0; l < NL; l++) begin
                rand_coeff(tbl_a[i][l]);
                rand_coeff(tbl_b[i][l]);
                rand_coeff(tbl_w[i][l]);
            end
        end

        n_valid = 0;
        for (int i = 0; i < N_ENTRIES; i++) begin
            if (tbl_vld[i]) begin
                n_valid++;
            end
            for (int l = 0; l < NL; l++) begin
                tbl_r0[i][l] = model_res0(tbl_op[i], tbl_a[i][l], tbl_b[i][l], tbl_w[i][l]);
                tbl_r1[i][l] = model_res1(tbl_op[i], tbl_a[i][l], tbl_b[i][l], tbl_w[i][l]);
            end
        end
    endtask

    task automatic drive_table();
        for (int i = 0; i < N_ENTRIES; i++) begin
            @(posedge clk);
            in_valid <= tbl_vld[i];
            op       <= tbl_op[i];
            for (int l = 0; l < NL; l++) begin
                a[l] <= coeff_t'(tbl_a[i][l]);
                b[l] <= coeff_t'(tbl_b[i][l]);
                w[l] <= coeff_t'(tbl_w[i][l]);
            end
            if (tbl_vld[i]) begin
                // sampled on the next edge and registered LATENCY edges later
                pend_idx.push_back(i);
                pend_edge.push_back(edge_cnt + 2 + `PE_LATENCY);
            end
        end
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    task automatic collect_results();
        int idx;
        int due;
        int waited;
        for (int n = 0; n < n_valid; n++) begin
            waited = 0;
            @(negedge clk);
            while (out_valid !== 1'b1) begin
                waited++;
                if (waited > WAIT_LIMIT) begin
                    $display("timed out waiting for out_valid, %0d results still due",
                             n_valid - n);
                    stop_run();
                end else begin
                    @(negedge clk);
                end
            end
            if (pend_idx.size() == 0) begin
                $display("out_valid went high with no sample in flight");
                stop_run();
            end else begin
                idx = pend_idx.pop_front();
                due = pend_edge.pop_front();
                check_value($sformatf("arrival_edge (entry %0d)", idx), edge_cnt, due);
                for (int l = 0; l < NL; l++) begin
                    check_value($sformatf("res0[%0d] (entry %0d)", l, idx),
                                res0[l], tbl_r0[idx][l]);
                    check_value($sformatf("res1[%0d] (entry %0d)", l, idx),
                                res1[l], tbl_r1[idx][l]);
                end
            end
        end
    endtask

    initial begin
        rst      = 1'b1;
        in_valid = 1'b0;
        op       = OP_MADD;
        for (int l = 0; l < NL; l++) begin
            a[l] = '0;
            b[l] = '0;
            w[l] = '0;
        end

        build_table();

        // out_valid must stay low throughout reset
        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(posedge clk);
            if (i == RESET_CYCLES - 1) begin
                rst <= 1'b0;
            end
            @(negedge clk);
            check_value("out_valid", out_valid, 32'd0);
        end

        fork
            drive_table();
            collect_results();
        join

        // nothing more may come out once the pipe drains
        for (int i = 0; i < TAIL_CYCLES; i++) begin
            @(negedge clk);
            check_value("out_valid", out_valid, 32'd0);
        end

        $display("all tests passed");
        $finish;
    end

endmodule

// File: compile.f
+incdir+hw
hw/pe_pkg.sv
hw/pe_lane_if.sv
hw/mod_add_sub.sv
hw/mod_mul.sv
hw/pe_lane.sv
hw/pe_array_top.sv
tb/tb_pe_array.sv
